// ==== rtl/id_consts.svh ====
/* decode stage constants */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_INST_W     32          // instruction word
`define ID_REG_IDX_W  5           // architectural register index
`define ID_ZERO_REG   5'd31       // reads zero, writes dropped
`define ID_LANES      2           // decode width and slot count
`define ID_CAP_W      2           // capacities and counts, 0..2

`define ID_OP_PAL     6'h00
`define ID_OP_LDA     6'h08
`define ID_OP_INTA    6'h10       // add, sub, compares
`define ID_OP_INTL    6'h11       // logicals
`define ID_OP_INTS    6'h12       // shifts
`define ID_OP_INTM    6'h13       // multiply
`define ID_OP_JSR     6'h1a       // jmp, jsr, ret, jsr_co
`define ID_OP_LDQ     6'h29
`define ID_OP_STQ     6'h2d
`define ID_OP_BR      6'h30
`define ID_OP_BSR     6'h34

`define ID_FN_ADDQ    7'h20
`define ID_FN_SUBQ    7'h29
`define ID_FN_CMPEQ   7'h2d
`define ID_FN_CMPLT   7'h4d
`define ID_FN_CMPLE   7'h6d
`define ID_FN_CMPULT  7'h1d
`define ID_FN_CMPULE  7'h3d
`define ID_FN_AND     7'h00
`define ID_FN_BIC     7'h08
`define ID_FN_BIS     7'h20
`define ID_FN_ORNOT   7'h28
`define ID_FN_XOR     7'h40
`define ID_FN_EQV     7'h48
`define ID_FN_SRL     7'h34
`define ID_FN_SLL     7'h39
`define ID_FN_SRA     7'h3c
`define ID_FN_MULQ    7'h20

`define ID_PAL_HALT   26'h0000000
`define ID_NOOP_INST  32'h47ff041f  // bis r31,r31,r31

`endif

// ==== rtl/id_pkg.sv ====
/* decode stage types */
`include "id_consts.svh"

package id_pkg;

  typedef struct packed {
    logic [5:0]               opcode;
    logic [`ID_REG_IDX_W-1:0] ra;
    logic [`ID_REG_IDX_W-1:0] rb;
    logic [2:0]               sbz;        // literal bits 2..0 when lit_flag set
    logic                     lit_flag;   // rb field holds an 8-bit literal
    logic [6:0]               func;
    logic [`ID_REG_IDX_W-1:0] rc;
  } op_fmt_t;

  typedef struct packed {
    logic [5:0]               opcode;
    logic [`ID_REG_IDX_W-1:0] ra;
    logic [`ID_REG_IDX_W-1:0] rb;
    logic [15:0]              disp;       // branches extend this through rb
  } mem_fmt_t;

  typedef union packed {
    op_fmt_t  op;
    mem_fmt_t mem;
  } inst_word_t;

  typedef enum logic [1:0] {
    OPA_IS_REGA     = 2'h0,
    OPA_IS_MEM_DISP = 2'h1,
    OPA_IS_NPC      = 2'h2,
    OPA_IS_NOT3     = 2'h3   // word-align mask for jumps
  } opa_sel_t;

  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'h0,
    OPB_IS_ALU_IMM = 2'h1,
    OPB_IS_BR_DISP = 2'h2
  } opb_sel_t;

  typedef enum logic [4:0] {
    ALU_ADDQ = 5'h00, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT,
    ALU_XOR, ALU_EQV, ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
    ALU_CMPULT, ALU_CMPEQ, ALU_CMPULE, ALU_CMPLT, ALU_CMPLE
  } alu_func_t;

  typedef struct packed {
    inst_word_t               ir;
    logic [`ID_REG_IDX_W-1:0] ra_idx;
    logic [`ID_REG_IDX_W-1:0] rb_idx;
    logic [`ID_REG_IDX_W-1:0] dest_idx;    // zero reg when nothing written
    opa_sel_t                 opa_select;
    opb_sel_t                 opb_select;
    alu_func_t                alu_func;
    logic                     rd_mem;
    logic                     wr_mem;
    logic                     cond_branch;
    logic                     uncond_branch;
    logic                     halt;
    logic                     illegal;
  } decoded_inst_t;

  // bis r31,r31,r31 fully decoded, used for empty lanes and slots
  localparam decoded_inst_t NOOP_DEC = '{
    ir: `ID_NOOP_INST, ra_idx: `ID_ZERO_REG, rb_idx: `ID_ZERO_REG,
    dest_idx: `ID_ZERO_REG, opa_select: OPA_IS_REGA, opb_select: OPB_IS_REGB,
    alu_func: ALU_BIS, rd_mem: 1'b0, wr_mem: 1'b0, cond_branch: 1'b0,
    uncond_branch: 1'b0, halt: 1'b0, illegal: 1'b0
  };

endpackage

// ==== rtl/decode_if.sv ====
/* decoder to buffer lanes */
`timescale 1ns/1ps

interface decode_if;
  import id_pkg::*;

  logic          lane_valid0;  // older lane
  logic          lane_valid1;  // only with lane_valid0
  decoded_inst_t lane_dec0;
  decoded_inst_t lane_dec1;

  modport producer (
    output lane_valid0,
    output lane_valid1,
    output lane_dec0,
    output lane_dec1
  );

  modport consumer (
    input lane_valid0,
    input lane_valid1,
    input lane_dec0,
    input lane_dec1
  );

endinterface

// ==== rtl/inst_decoder.sv ====
/* two-lane instruction decoder */
`timescale 1ns/1ps
`include "id_consts.svh"

module inst_decoder (
  decode_if.producer                        lanes,
  input  id_pkg::inst_word_t [`ID_LANES-1:0] if_ir,
  input  logic [`ID_LANES-1:0]              if_valid
);
  import id_pkg::*;

  // one lane of decode, purely combinational
  function automatic decoded_inst_t decode_lane(input inst_word_t ir, input logic valid);
    decoded_inst_t d;
    d = NOOP_DEC;                                   // invalid lane stays a noop
    if (valid)
    begin
      d.ir     = ir;
      d.ra_idx = ir.mem.ra;
      d.rb_idx = ir.mem.rb;
      case (ir.mem.opcode)
        `ID_OP_PAL:
        begin
          if ({ir.mem.ra, ir.mem.rb, ir.mem.disp} == `ID_PAL_HALT)
            d.halt = 1'b1;
          else
            d.illegal = 1'b1;                       // whami and other pal calls
        end
        `ID_OP_INTA, `ID_OP_INTL, `ID_OP_INTS, `ID_OP_INTM:
        begin
          d.opa_select = OPA_IS_REGA;
          d.opb_select = ir.op.lit_flag ? OPB_IS_ALU_IMM : OPB_IS_REGB;
          d.dest_idx   = ir.op.rc;
          case (ir.op.opcode)
            `ID_OP_INTA:
              case (ir.op.func)
                `ID_FN_ADDQ:   d.alu_func = ALU_ADDQ;
                `ID_FN_SUBQ:   d.alu_func = ALU_SUBQ;
                `ID_FN_CMPEQ:  d.alu_func = ALU_CMPEQ;
                `ID_FN_CMPLT:  d.alu_func = ALU_CMPLT;
                `ID_FN_CMPLE:  d.alu_func = ALU_CMPLE;
                `ID_FN_CMPULT: d.alu_func = ALU_CMPULT;
                `ID_FN_CMPULE: d.alu_func = ALU_CMPULE;
                default:       d.illegal  = 1'b1;
              endcase
            `ID_OP_INTL:
              case (ir.op.func)
                `ID_FN_AND:    d.alu_func = ALU_AND;
                `ID_FN_BIC:    d.alu_func = ALU_BIC;
                `ID_FN_BIS:    d.alu_func = ALU_BIS;
                `ID_FN_ORNOT:  d.alu_func = ALU_ORNOT;
                `ID_FN_XOR:    d.alu_func = ALU_XOR;
                `ID_FN_EQV:    d.alu_func = ALU_EQV;
                default:       d.illegal  = 1'b1;
              endcase
            `ID_OP_INTS:
              case (ir.op.func)
                `ID_FN_SRL:    d.alu_func = ALU_SRL;
                `ID_FN_SLL:    d.alu_func = ALU_SLL;
                `ID_FN_SRA:    d.alu_func = ALU_SRA;
                default:       d.illegal  = 1'b1;
              endcase
            default:                                // intm group
              if (ir.op.func == `ID_FN_MULQ)
                d.alu_func = ALU_MULQ;
              else
                d.illegal = 1'b1;
          endcase
        end
        `ID_OP_LDA, `ID_OP_LDQ, `ID_OP_STQ:
        begin
          d.opa_select = OPA_IS_MEM_DISP;           // disp + rb
          d.opb_select = OPB_IS_REGB;
          d.alu_func   = ALU_ADDQ;
          d.dest_idx   = ir.mem.ra;
          if (ir.mem.opcode == `ID_OP_LDQ)
            d.rd_mem = 1'b1;
          if (ir.mem.opcode == `ID_OP_STQ)
          begin
            d.wr_mem   = 1'b1;
            d.dest_idx = `ID_ZERO_REG;              // ra is store data
          end
        end
        `ID_OP_JSR:
        begin
          d.opa_select    = OPA_IS_NOT3;            // target rb & ~3
          d.opb_select    = OPB_IS_REGB;
          d.alu_func      = ALU_AND;
          d.dest_idx      = ir.mem.ra;              // return address
          d.uncond_branch = 1'b1;
        end
        `ID_OP_BR, `ID_OP_BSR:
        begin
          d.opa_select    = OPA_IS_NPC;
          d.opb_select    = OPB_IS_BR_DISP;
          d.alu_func      = ALU_ADDQ;
          d.dest_idx      = ir.mem.ra;
          d.uncond_branch = 1'b1;
        end
        default:
        begin
          if (ir.mem.opcode[5:3] == 3'b111)         // integer cond branches 0x38..0x3f
          begin
            d.opa_select  = OPA_IS_NPC;
            d.opb_select  = OPB_IS_BR_DISP;
            d.alu_func    = ALU_ADDQ;
            d.cond_branch = 1'b1;
          end
          else
            d.illegal = 1'b1;                       // fp, ll/sc, misc
        end
      endcase
      if (d.illegal)
        d.dest_idx = `ID_ZERO_REG;                  // never writes back
    end
    return d;
  endfunction

  assign lanes.lane_valid0 = if_valid[0];
  assign lanes.lane_valid1 = if_valid[1] & if_valid[0];  // keep lanes in prefix order
  assign lanes.lane_dec0   = decode_lane(if_ir[0], if_valid[0]);
  assign lanes.lane_dec1   = decode_lane(if_ir[1], if_valid[1] & if_valid[0]);

endmodule

// ==== rtl/dispatch_buffer.sv ====
/* two-entry dispatch buffer */
`timescale 1ns/1ps
`include "id_consts.svh"

module dispatch_buffer (
  input  logic                                 clock,
  input  logic                                 reset,
  decode_if.consumer                           lanes,
  input  logic [`ID_CAP_W-1:0]                 rob_cap,
  input  logic [`ID_CAP_W-1:0]                 rs_cap,
  output id_pkg::decoded_inst_t [`ID_LANES-1:0] slot,
  output logic [`ID_LANES-1:0]                 slot_valid,
  output logic [`ID_CAP_W-1:0]                 dispatch_num,
  output logic [`ID_CAP_W-1:0]                 fetch_need
);
  import id_pkg::*;

  logic [`ID_CAP_W-1:0]         occ;         // occupied slots
  logic [`ID_CAP_W-1:0]         cap_min;
  logic [`ID_CAP_W-1:0]         keep;        // survivors after dispatch
  logic [`ID_CAP_W-1:0]         lane_cnt;
  logic [`ID_CAP_W-1:0]         take;        // lanes accepted this edge
  logic [`ID_CAP_W-1:0]         fill;
  decoded_inst_t [`ID_LANES-1:0] lane_dec;
  decoded_inst_t [`ID_LANES-1:0] nxt_slot;
  logic [`ID_LANES-1:0]         nxt_valid;

  assign lane_dec = {lanes.lane_dec1, lanes.lane_dec0};
  assign occ      = {1'b0, slot_valid[0]} + {1'b0, slot_valid[1]};
  assign lane_cnt = {1'b0, lanes.lane_valid0} + {1'b0, lanes.lane_valid1};

  // dispatch as many as both back ends can take
  assign cap_min      = (rob_cap < rs_cap) ? rob_cap : rs_cap;
  assign dispatch_num = (occ < cap_min) ? occ : cap_min;
  assign keep         = occ - dispatch_num;
  assign fetch_need   = `ID_CAP_W'(`ID_LANES) - keep;   // free after this edge
  assign take         = (lane_cnt < fetch_need) ? lane_cnt : fetch_need;
  assign fill         = keep + take;

  // survivors first, then new lanes, packed from slot 0
  always_comb
  begin
    case (keep)
      2'd2:
      begin
        nxt_slot[0] = slot[0];                  // nothing left
        nxt_slot[1] = slot[1];
      end
      2'd1:
      begin
        nxt_slot[0] = dispatch_num[0] ? slot[1] : slot[0];  // oldest survivor
        nxt_slot[1] = lane_dec[0];
      end
      default:
      begin
        nxt_slot[0] = lane_dec[0];              // noop if lane empty
        nxt_slot[1] = lane_dec[1];
      end
    endcase
    nxt_valid[0] = (fill != '0);
    nxt_valid[1] = fill[1];                     // fill never above 2
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      slot_valid <= '0;
      slot       <= {`ID_LANES{NOOP_DEC}};
    end
    else
    begin
      slot_valid <= nxt_valid;
      slot       <= nxt_slot;
    end
  end

endmodule

// ==== rtl/id_stage.sv ====
/* decode and dispatch stage */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic [`ID_LANES-1:0][`ID_INST_W-1:0]            if_ir,
  input  logic [`ID_LANES-1:0]                            if_valid,
  input  logic [`ID_CAP_W-1:0]                            rob_cap,
  input  logic [`ID_CAP_W-1:0]                            rs_cap,
  output logic [`ID_LANES-1:0][`ID_INST_W-1:0]            disp_ir,
  output logic [`ID_LANES-1:0][`ID_REG_IDX_W-1:0]         disp_ra_idx,
  output logic [`ID_LANES-1:0][`ID_REG_IDX_W-1:0]         disp_rb_idx,
  output logic [`ID_LANES-1:0][`ID_REG_IDX_W-1:0]         disp_dest_idx,
  output logic [`ID_LANES-1:0][$bits(id_pkg::opa_sel_t)-1:0]  disp_opa_select,
  output logic [`ID_LANES-1:0][$bits(id_pkg::opb_sel_t)-1:0]  disp_opb_select,
  output logic [`ID_LANES-1:0][$bits(id_pkg::alu_func_t)-1:0] disp_alu_func,
  output logic [`ID_LANES-1:0]                            disp_rd_mem,
  output logic [`ID_LANES-1:0]                            disp_wr_mem,
  output logic [`ID_LANES-1:0]                            disp_cond_branch,
  output logic [`ID_LANES-1:0]                            disp_uncond_branch,
  output logic [`ID_LANES-1:0]                            disp_halt,
  output logic [`ID_LANES-1:0]                            disp_illegal,
  output logic [`ID_LANES-1:0]                            disp_valid,
  output logic [`ID_CAP_W-1:0]                            dispatch_num,
  output logic [`ID_CAP_W-1:0]                            fetch_need
);
  import id_pkg::*;

  decoded_inst_t [`ID_LANES-1:0] slot;   // registered, slot 0 oldest

  decode_if lanes_if ();

  inst_decoder decoder0 (
    .lanes    (lanes_if.producer),
    .if_ir    (if_ir),
    .if_valid (if_valid)
  );

  dispatch_buffer buffer0 (
    .clock        (clock),
    .reset        (reset),
    .lanes        (lanes_if.consumer),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .slot         (slot),
    .slot_valid   (disp_valid),
    .dispatch_num (dispatch_num),
    .fetch_need   (fetch_need)
  );

  // flatten slot structs onto per-field ports
  always_comb
  begin
    for (int i = 0; i < `ID_LANES; i++)
    begin
      disp_ir[i]            = slot[i].ir;
      disp_ra_idx[i]        = slot[i].ra_idx;
      disp_rb_idx[i]        = slot[i].rb_idx;
      disp_dest_idx[i]      = slot[i].dest_idx;
      disp_opa_select[i]    = slot[i].opa_select;
      disp_opb_select[i]    = slot[i].opb_select;
      disp_alu_func[i]      = slot[i].alu_func;
      disp_rd_mem[i]        = slot[i].rd_mem;
      disp_wr_mem[i]        = slot[i].wr_mem;
      disp_cond_branch[i]   = slot[i].cond_branch;
      disp_uncond_branch[i] = slot[i].uncond_branch;
      disp_halt[i]          = slot[i].halt;
      disp_illegal[i]       = slot[i].illegal;
    end
  end

endmodule

// ==== verif/id_stage_props.sv ====
/* dispatch buffer checks */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage_props (
  input logic                 clock,
  input logic                 reset,
  input logic [`ID_CAP_W-1:0] rob_cap,
  input logic [`ID_CAP_W-1:0] rs_cap,
  input logic [`ID_LANES-1:0] slot_valid,
  input logic [`ID_CAP_W-1:0] dispatch_num,
  input logic [`ID_CAP_W-1:0] fetch_need
);
  int                   fail_count = 0;  // failed assertions so far
  logic [`ID_CAP_W-1:0] occ;

  assign occ = {1'b0, slot_valid[0]} + {1'b0, slot_valid[1]};

  task automatic record_failure(input string what);
    $error("%s", what);
    fail_count = fail_count + 1;
  endtask

  // slots not offered to fetch are still held after the edge
  need_rule: assert property (@(posedge clock) disable iff (reset)
    1'b1 |=> occ >= 2'd2 - $past(fetch_need))
    else record_failure("fetch_need above the free slots or a held entry lost");

  disp_bound: assert property (@(posedge clock) disable iff (reset)
    dispatch_num <= rob_cap && dispatch_num <= rs_cap && dispatch_num <= occ)
    else record_failure("dispatch_num above a capacity or the occupancy");

  slot_prefix: assert property (@(posedge clock) disable iff (reset)
    slot_valid[1] |-> slot_valid[0])
    else record_failure("slot 1 valid while slot 0 empty");

  // idle outputs in the cycle after reset
  reset_idle: assert property (@(posedge clock)
    reset |=> (slot_valid == '0 && dispatch_num == '0 && fetch_need == 2'd2))
    else record_failure("buffer not idle after reset");

endmodule

bind dispatch_buffer id_stage_props props0 (
  .clock        (clock),
  .reset        (reset),
  .rob_cap      (rob_cap),
  .rs_cap       (rs_cap),
  .slot_valid   (slot_valid),
  .dispatch_num (dispatch_num),
  .fetch_need   (fetch_need)
);

// ==== verif/id_stage_tb.sv ====
/* decode stage testbench */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage_tb;
  import id_pkg::*;

  typedef struct packed {
    logic [31:0] ir;
    logic [19:0] exp;   // dest, opa, opb, alu, rd, wr, cond, uncond, halt, illegal
    logic [19:0] mask;  // flags only for halt and illegal
  } entry_t;

  logic                                 clock = 1'b0;
  logic                                 reset;
  logic [`ID_LANES-1:0][`ID_INST_W-1:0] if_ir;
  logic [`ID_LANES-1:0]                 if_valid;
  logic [`ID_CAP_W-1:0]                 rob_cap;
  logic [`ID_CAP_W-1:0]                 rs_cap;
  logic [`ID_LANES-1:0][`ID_INST_W-1:0] disp_ir;
  logic [`ID_LANES-1:0][4:0]            disp_ra_idx;
  logic [`ID_LANES-1:0][4:0]            disp_rb_idx;
  logic [`ID_LANES-1:0][4:0]            disp_dest_idx;
  logic [`ID_LANES-1:0][1:0]            disp_opa_select;
  logic [`ID_LANES-1:0][1:0]            disp_opb_select;
  logic [`ID_LANES-1:0][4:0]            disp_alu_func;
  logic [`ID_LANES-1:0]                 disp_rd_mem;
  logic [`ID_LANES-1:0]                 disp_wr_mem;
  logic [`ID_LANES-1:0]                 disp_cond_branch;
  logic [`ID_LANES-1:0]                 disp_uncond_branch;
  logic [`ID_LANES-1:0]                 disp_halt;
  logic [`ID_LANES-1:0]                 disp_illegal;
  logic [`ID_LANES-1:0]                 disp_valid;
  logic [`ID_CAP_W-1:0]                 dispatch_num;
  logic [`ID_CAP_W-1:0]                 fetch_need;

  int unsigned lcg_state = 33;
  entry_t      stream[$];  // fetch order, not yet accepted
  entry_t      held[$];    // expected slot contents, oldest first
  int          i;
  int          cyc;
  int          occ;
  int          cap;
  int          dn;
  int          n_lanes;
  int          n_take;
  logic        stall;
  logic [19:0] got;

  id_stage dut0 (.*);

  always #50 clock = ~clock;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // low bits cycle too fast
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (expected == actual)
      else fail_run($sformatf("ERROR %s expected %0h actual %0h", test, expected, actual));
  endtask

  // instruction of a given kind and the decode it must produce
  function automatic entry_t make_entry(input int kind);
    entry_t      e;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic        lit;
    logic [1:0]  opb;
    logic [15:0] disp;
    ra     = 5'(next_rand());
    rb     = 5'(next_rand());
    rc     = 5'(next_rand());
    lit    = 1'(next_rand());
    disp   = 16'(next_rand());
    opb    = lit ? OPB_IS_ALU_IMM : OPB_IS_REGB;  // literal replaces rb
    e.mask = '1;
    case (kind)
      0:       e.ir = {`ID_OP_INTA, ra, rb, 3'b0, lit, `ID_FN_ADDQ, rc};
      1:       e.ir = {`ID_OP_INTL, ra, rb, 3'b0, lit, `ID_FN_AND, rc};
      2:       e.ir = {`ID_OP_INTS, ra, rb, 3'b0, lit, `ID_FN_SLL, rc};
      3:       e.ir = {`ID_OP_INTM, ra, rb, 3'b0, lit, `ID_FN_MULQ, rc};
      4:       e.ir = {`ID_OP_LDQ, ra, rb, disp};
      5:       e.ir = {`ID_OP_STQ, ra, rb, disp};
      6:       e.ir = {`ID_OP_LDA, ra, rb, disp};
      7:       e.ir = {`ID_OP_BR, ra, rb, disp};
      8:       e.ir = {`ID_OP_BSR, ra, rb, disp};
      9:       e.ir = {6'h39, ra, rb, disp};                     // beq
      10:      e.ir = {`ID_OP_JSR, ra, rb, 2'b00, disp[13:0]};   // jmp
      11:      e.ir = {`ID_OP_PAL, `ID_PAL_HALT};
      12:      e.ir = {6'h16, ra, rb, disp};                     // fp operate group
      13:      e.ir = {`ID_OP_INTA, ra, rb, 3'b0, lit, 7'h7f, rc};  // no such function
      default: e.ir = {`ID_OP_PAL, 26'h000003c};                  // whami
    endcase
    case (kind)
      0:       e.exp = {rc, OPA_IS_REGA, opb, ALU_ADDQ, 6'b000000};
      1:       e.exp = {rc, OPA_IS_REGA, opb, ALU_AND, 6'b000000};
      2:       e.exp = {rc, OPA_IS_REGA, opb, ALU_SLL, 6'b000000};
      3:       e.exp = {rc, OPA_IS_REGA, opb, ALU_MULQ, 6'b000000};
      4:       e.exp = {ra, OPA_IS_MEM_DISP, OPB_IS_REGB, ALU_ADDQ, 6'b100000};
      5:       e.exp = {5'd31, OPA_IS_MEM_DISP, OPB_IS_REGB, ALU_ADDQ, 6'b010000};
      6:       e.exp = {ra, OPA_IS_MEM_DISP, OPB_IS_REGB, ALU_ADDQ, 6'b000000};
      7, 8:    e.exp = {ra, OPA_IS_NPC, OPB_IS_BR_DISP, ALU_ADDQ, 6'b000100};
      9:       e.exp = {5'd31, OPA_IS_NPC, OPB_IS_BR_DISP, ALU_ADDQ, 6'b001000};
      10:      e.exp = {ra, OPA_IS_NOT3, OPB_IS_REGB, ALU_AND, 6'b000100};
      11:      e.exp = 20'h00002;
      default: e.exp = 20'h00001;
    endcase
    if (kind >= 11)
      e.mask = 20'h0003f;  // only the six flags
    return e;
  endfunction

  // bound assertions count their failures
  always @(negedge clock)
  begin
    if (dut0.buffer0.props0.fail_count != 0)
      fail_run("a concurrent assertion failed in the dispatch buffer");
  end

  initial
  begin
    reset    = 1'b1;
    if_ir    = '0;
    if_valid = '0;
    rob_cap  = '0;
    rs_cap   = '0;
    for (i = 0; i < 75; i++)
      stream.push_back(make_entry(i < 15 ? i : int'(next_rand() % 15)));  // directed, then random
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_eq("reset disp_valid", 0, 32'(disp_valid));
    check_eq("reset dispatch_num", 0, 32'(dispatch_num));
    check_eq("reset fetch_need", 2, 32'(fetch_need));
    for (cyc = 0; cyc < 600 && (stream.size() != 0 || held.size() != 0); cyc++)
    begin
      @(posedge clock);
      stall   = (cyc >= 20 && cyc < 26);                    // both back ends full
      rob_cap <= stall ? 2'd0 : 2'(next_rand() % 3);
      rs_cap  <= stall ? 2'd0 : 2'(next_rand() % 3);
      n_lanes = stall ? 2 : int'(next_rand() % 3);
      if (n_lanes > stream.size())
        n_lanes = stream.size();
      if_valid <= 2'((1 << n_lanes) - 1);
      if_ir[0] <= (n_lanes > 0) ? stream[0].ir : next_rand();  // junk on idle lanes
      if_ir[1] <= (n_lanes > 1) ? stream[1].ir : next_rand();
      @(negedge clock);
      occ = held.size();
      cap = (rob_cap < rs_cap) ? int'(rob_cap) : int'(rs_cap);
      dn  = (occ < cap) ? occ : cap;
      check_eq("dispatch_num", dn, 32'(dispatch_num));
      check_eq("fetch_need", 2 - occ + dn, 32'(fetch_need));
      check_eq("disp_valid", (1 << occ) - 1, 32'(disp_valid));
      if (stall && occ == 2)
        check_eq("full stall fetch_need", 0, 32'(fetch_need));
      for (i = 0; i < occ; i++)
      begin
        got = {disp_dest_idx[1'(i)], disp_opa_select[1'(i)], disp_opb_select[1'(i)],
               disp_alu_func[1'(i)], disp_rd_mem[1'(i)], disp_wr_mem[1'(i)],
               disp_cond_branch[1'(i)], disp_uncond_branch[1'(i)], disp_halt[1'(i)],
               disp_illegal[1'(i)]};
        check_eq("slot order", held[i].ir, disp_ir[1'(i)]);
        check_eq("ra_idx", 32'(held[i].ir[25:21]), 32'(disp_ra_idx[1'(i)]));  // ra field
        check_eq("rb_idx", 32'(held[i].ir[20:16]), 32'(disp_rb_idx[1'(i)]));  // rb field
        check_eq($sformatf("decode of %h", held[i].ir), 32'(held[i].exp),
                 32'(got & held[i].mask));
      end
      repeat (dn) void'(held.pop_front());                 // oldest leave first
      n_take = (n_lanes < 2 - occ + dn) ? n_lanes : 2 - occ + dn;
      repeat (n_take) held.push_back(stream.pop_front());
    end
    if (stream.size() != 0 || held.size() != 0)
      fail_run("timeout: instructions still pending after 600 cycles");
    else if (dut0.buffer0.props0.fail_count != 0)
      fail_run("a concurrent assertion failed in the dispatch buffer");
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/id_pkg.sv
rtl/decode_if.sv
rtl/inst_decoder.sv
rtl/dispatch_buffer.sv
rtl/id_stage.sv
verif/id_stage_props.sv
verif/id_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module id_stage_tb

# keep running past assertion errors so the testbench reports them
./obj_dir/Vid_stage_tb +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
